/* vproc_defs.svh */
`ifndef VPROC_DEFS_SVH
`define VPROC_DEFS_SVH

// scalar word and vector lane width.
`define VPROC_XLEN 32

// lanes per vector register.
`define VPROC_LANES 4

// entries in each register file.
`define VPROC_NREGS 32

// stages in the vector execute unit.
`define VPROC_VLAT 3

// instruction encoding widths.
`define VPROC_OPW 6
`define VPROC_IMMW 16

`endif

/* vproc_isa_pkg.sv */
`default_nettype none

`include "vproc_defs.svh"

package vproc_isa_pkg;

    typedef logic [`VPROC_XLEN-1:0] word_t;
    typedef logic [$clog2(`VPROC_NREGS)-1:0] reg_idx_t;
    typedef logic [`VPROC_LANES-1:0][`VPROC_XLEN-1:0] vec_t; // lane 0 in the low bits.

    typedef enum logic [`VPROC_OPW-1:0] {
        op_sadd   = 'h01,
        op_ssub   = 'h02,
        op_saddi  = 'h03,
        op_sand   = 'h04,
        op_vadd   = 'h10,
        op_vmul   = 'h11,
        op_vsplat = 'h12
    } opcode_e;

    // rs2 shares its bits with the top of the immediate.
    typedef struct packed {
        opcode_e                op;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        logic [`VPROC_IMMW-1:0] imm;
    } inst_t;

    function automatic reg_idx_t inst_rs2(inst_t i);
        return i.imm[`VPROC_IMMW-1 -: $bits(reg_idx_t)];
    endfunction

    function automatic word_t inst_imm(inst_t i);
        return {{(`VPROC_XLEN-`VPROC_IMMW){i.imm[`VPROC_IMMW-1]}}, i.imm}; // sign extend.
    endfunction

endpackage

`default_nettype wire

/* vproc_ctrl_pkg.sv */
`default_nettype none

package vproc_ctrl_pkg;

    // scalar pipeline control, one per issued scalar instruction.
    typedef struct packed {
        logic                    valid;
        vproc_isa_pkg::opcode_e  op;
        vproc_isa_pkg::reg_idx_t rd;
        logic                    use_imm; // second operand is the immediate.
    } s_ctrl_t;

    // vector pipeline control, rides alongside the lane data.
    typedef struct packed {
        logic                    valid;
        vproc_isa_pkg::opcode_e  op;
        vproc_isa_pkg::reg_idx_t rd;
    } v_ctrl_t;

endpackage

`default_nettype wire

/* wb_if.sv */
`default_nettype none

interface wb_if #(
    parameter type T = vproc_isa_pkg::word_t
);

    logic                    we;   // one cycle per retired result.
    vproc_isa_pkg::reg_idx_t addr;
    T                        data;

    modport src (
        output we,
        output addr,
        output data
    );

    modport dst (
        input we,
        input addr,
        input data
    );

endinterface

`default_nettype wire

/* control_pipeline.sv */
`default_nettype none

module control_pipeline #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  T     control_d,
    output T     control_q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            control_q <= '0;
        end else begin
            control_q <= control_d;
        end
    end

endmodule

`default_nettype wire

/* decode_regfile.sv */
`default_nettype none

`include "vproc_defs.svh"

module decode_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_valid,
    input  vproc_isa_pkg::word_t    inst,
    wb_if.dst                       s_wb,
    wb_if.dst                       v_wb,
    output vproc_ctrl_pkg::s_ctrl_t s_ctrl,
    output vproc_ctrl_pkg::v_ctrl_t v_ctrl,
    output vproc_isa_pkg::word_t    sdata1,
    output vproc_isa_pkg::word_t    sdata2,
    output vproc_isa_pkg::word_t    imm,
    output vproc_isa_pkg::vec_t     vdata1,
    output vproc_isa_pkg::vec_t     vdata2,
    output logic                    err
);

    vproc_isa_pkg::inst_t    f;
    vproc_isa_pkg::reg_idx_t rs2;
    vproc_isa_pkg::word_t    sregs [`VPROC_NREGS];
    vproc_isa_pkg::vec_t     vregs [`VPROC_NREGS];
    vproc_isa_pkg::word_t    s_rd1;
    vproc_isa_pkg::word_t    s_rd2;
    vproc_isa_pkg::vec_t     v_rd1;
    vproc_isa_pkg::vec_t     v_rd2;
    vproc_ctrl_pkg::s_ctrl_t s_next;
    vproc_ctrl_pkg::v_ctrl_t v_next;
    logic                    s_wr;
    logic                    v_wr;
    logic                    illegal;

    assign f    = vproc_isa_pkg::inst_t'(inst);
    assign rs2  = vproc_isa_pkg::inst_rs2(f);
    assign s_wr = s_wb.we && (s_wb.addr != '0); // register 0 is never written.
    assign v_wr = v_wb.we && (v_wb.addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `VPROC_NREGS; i++) begin
                sregs[i] <= '0;
                vregs[i] <= '0;
            end
        end else begin
            if (s_wr) begin
                sregs[s_wb.addr] <= s_wb.data;
            end
            if (v_wr) begin
                vregs[v_wb.addr] <= v_wb.data;
            end
        end
    end

    // write-first, so a result retiring this cycle is seen by the reader.
    always_comb begin
        s_rd1 = (s_wr && s_wb.addr == f.rs1) ? s_wb.data : sregs[f.rs1];
        s_rd2 = (s_wr && s_wb.addr == rs2) ? s_wb.data : sregs[rs2];
        v_rd1 = (v_wr && v_wb.addr == f.rs1) ? v_wb.data : vregs[f.rs1];
        v_rd2 = (v_wr && v_wb.addr == rs2) ? v_wb.data : vregs[rs2];
    end

    // steer by opcode.
    always_comb begin
        s_next  = '0;
        v_next  = '0;
        illegal = 1'b0;
        if (inst_valid) begin
            case (f.op)
                vproc_isa_pkg::op_sadd, vproc_isa_pkg::op_ssub,
                vproc_isa_pkg::op_sand, vproc_isa_pkg::op_saddi: begin
                    s_next.valid   = 1'b1;
                    s_next.op      = f.op;
                    s_next.rd      = f.rd;
                    s_next.use_imm = (f.op == vproc_isa_pkg::op_saddi);
                end
                vproc_isa_pkg::op_vadd, vproc_isa_pkg::op_vmul,
                vproc_isa_pkg::op_vsplat: begin
                    v_next.valid = 1'b1;
                    v_next.op    = f.op;
                    v_next.rd    = f.rd;
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        sdata1 <= s_rd1; // also the splat source.
        sdata2 <= s_rd2;
        imm    <= vproc_isa_pkg::inst_imm(f);
        vdata1 <= v_rd1;
        vdata2 <= v_rd2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err <= 1'b0;
        end else begin
            err <= illegal;
        end
    end

    control_pipeline #(.T(vproc_ctrl_pkg::s_ctrl_t)) u_s_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .control_d (s_next),
        .control_q (s_ctrl)
    );

    control_pipeline #(.T(vproc_ctrl_pkg::v_ctrl_t)) u_v_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .control_d (v_next),
        .control_q (v_ctrl)
    );

endmodule

`default_nettype wire

/* scalar_alu.sv */
`default_nettype none

`include "vproc_defs.svh"

module scalar_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  vproc_ctrl_pkg::s_ctrl_t s_ctrl,
    input  vproc_isa_pkg::word_t    sdata1,
    input  vproc_isa_pkg::word_t    sdata2,
    input  vproc_isa_pkg::word_t    imm,
    wb_if.src                       wb,
    output logic                    zero,
    output logic                    sign
);

    vproc_isa_pkg::word_t opb;
    vproc_isa_pkg::word_t result;

    always_comb begin
        opb = s_ctrl.use_imm ? imm : sdata2;
        case (s_ctrl.op)
            vproc_isa_pkg::op_sadd, vproc_isa_pkg::op_saddi: result = sdata1 + opb;
            vproc_isa_pkg::op_ssub: result = sdata1 - opb;
            vproc_isa_pkg::op_sand: result = sdata1 & opb;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.we <= 1'b0;
            zero  <= 1'b0;
            sign  <= 1'b0;
        end else begin
            wb.we <= s_ctrl.valid && (s_ctrl.rd != '0); // a write to r0 never retires.
            if (s_ctrl.valid) begin
                zero <= (result == '0);
                sign <= result[`VPROC_XLEN-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_ctrl.valid) begin
            wb.addr <= s_ctrl.rd;
            wb.data <= result;
        end
    end

endmodule

`default_nettype wire

/* vector_lanes.sv */
`default_nettype none

`include "vproc_defs.svh"

module vector_lanes (
    input  logic                    clk,
    input  logic                    rst_n,
    input  vproc_ctrl_pkg::v_ctrl_t v_ctrl,
    input  vproc_isa_pkg::vec_t     vdata1,
    input  vproc_isa_pkg::vec_t     vdata2,
    input  vproc_isa_pkg::word_t    sdata1,
    wb_if.src                       wb
);

    vproc_isa_pkg::vec_t     result;
    vproc_ctrl_pkg::v_ctrl_t ctrl_chain [`VPROC_VLAT+1]; // entry 0 is the unregistered input.
    vproc_isa_pkg::vec_t     data_chain [`VPROC_VLAT+1];

    always_comb begin
        for (int i = 0; i < `VPROC_LANES; i++) begin
            case (v_ctrl.op)
                vproc_isa_pkg::op_vadd:   result[i] = vdata1[i] + vdata2[i];
                vproc_isa_pkg::op_vmul:   result[i] = vdata1[i] * vdata2[i]; // low word only.
                vproc_isa_pkg::op_vsplat: result[i] = sdata1;
                default:                  result[i] = '0;
            endcase
        end
    end

    assign ctrl_chain[0] = v_ctrl;
    assign data_chain[0] = result;

    for (genvar s = 0; s < `VPROC_VLAT; s++) begin : g_stage
        control_pipeline #(.T(vproc_ctrl_pkg::v_ctrl_t)) u_ctrl (
            .clk       (clk),
            .rst_n     (rst_n),
            .control_d (ctrl_chain[s]),
            .control_q (ctrl_chain[s+1])
        );

        control_pipeline #(.T(vproc_isa_pkg::vec_t)) u_data (
            .clk       (clk),
            .rst_n     (rst_n),
            .control_d (data_chain[s]),
            .control_q (data_chain[s+1])
        );
    end

    // last stage retires straight onto the bus.
    assign wb.we   = ctrl_chain[`VPROC_VLAT].valid && (ctrl_chain[`VPROC_VLAT].rd != '0);
    assign wb.addr = ctrl_chain[`VPROC_VLAT].rd;
    assign wb.data = data_chain[`VPROC_VLAT];

endmodule

`default_nettype wire

/* vproc_top.sv */
`default_nettype none

`include "vproc_defs.svh"

module vproc_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  inst_valid,
    input  logic [`VPROC_XLEN-1:0]                inst,
    output logic                                  s_wb_we,
    output logic [$clog2(`VPROC_NREGS)-1:0]       s_wb_addr,
    output logic [`VPROC_XLEN-1:0]                s_wb_data,
    output logic                                  v_wb_we,
    output logic [$clog2(`VPROC_NREGS)-1:0]       v_wb_addr,
    output logic [`VPROC_LANES*`VPROC_XLEN-1:0]   v_wb_data,
    output logic                                  zero,
    output logic                                  sign,
    output logic                                  err
);

    vproc_ctrl_pkg::s_ctrl_t s_ctrl;
    vproc_ctrl_pkg::v_ctrl_t v_ctrl;
    vproc_isa_pkg::word_t    sdata1;
    vproc_isa_pkg::word_t    sdata2;
    vproc_isa_pkg::word_t    imm;
    vproc_isa_pkg::vec_t     vdata1;
    vproc_isa_pkg::vec_t     vdata2;

    wb_if #(.T(vproc_isa_pkg::word_t)) s_wb ();
    wb_if #(.T(vproc_isa_pkg::vec_t))  v_wb ();

    decode_regfile u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .s_wb       (s_wb.dst),
        .v_wb       (v_wb.dst),
        .s_ctrl     (s_ctrl),
        .v_ctrl     (v_ctrl),
        .sdata1     (sdata1),
        .sdata2     (sdata2),
        .imm        (imm),
        .vdata1     (vdata1),
        .vdata2     (vdata2),
        .err        (err)
    );

    scalar_alu u_salu (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_ctrl (s_ctrl),
        .sdata1 (sdata1),
        .sdata2 (sdata2),
        .imm    (imm),
        .wb     (s_wb.src),
        .zero   (zero),
        .sign   (sign)
    );

    vector_lanes u_vlanes (
        .clk    (clk),
        .rst_n  (rst_n),
        .v_ctrl (v_ctrl),
        .vdata1 (vdata1),
        .vdata2 (vdata2),
        .sdata1 (sdata1),
        .wb     (v_wb.src)
    );

    assign s_wb_we   = s_wb.we;
    assign s_wb_addr = s_wb.addr;
    assign s_wb_data = s_wb.data;
    assign v_wb_we   = v_wb.we;
    assign v_wb_addr = v_wb.addr;
    assign v_wb_data = v_wb.data; // lane 0 lands in the low word.

endmodule

`default_nettype wire

/* vproc_assertions.sv */
`default_nettype none

`include "vproc_defs.svh"

module vproc_assertions (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            s_wb_we,
    input logic [$clog2(`VPROC_NREGS)-1:0] s_wb_addr,
    input logic                            v_wb_we,
    input logic                            zero,
    input logic                            sign,
    input logic                            err
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned fails = 0; // read by the testbench at the end of the run.

    property quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> !(err || s_wb_we || v_wb_we || zero || sign);
    endproperty

    property err_single_cycle;
        @(posedge clk) disable iff (!rst_n) err |=> !err;
    endproperty

    property scalar_wb_not_r0;
        @(posedge clk) disable iff (!rst_n) s_wb_we |-> (s_wb_addr != '0);
    endproperty

    a_quiet: assert property (quiet_after_reset) else begin
        fails++;
        $error("outputs active on the first cycle after reset");
    end

    a_err_pulse: assert property (err_single_cycle) else begin
        fails++;
        $error("err high for two cycles in a row");
    end

    a_wb_addr: assert property (scalar_wb_not_r0) else begin
        fails++;
        $error("scalar writeback addressed to register 0");
    end

endmodule

`default_nettype wire

/* tb_vproc.sv */
`default_nettype none

`include "vproc_defs.svh"

module tb_vproc;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int n_scalar = 24;
    localparam int n_vector = 12;
    localparam int xw       = `VPROC_XLEN;
    localparam int vw       = `VPROC_LANES * `VPROC_XLEN;
    // clock cycles the stimulus spends including six drains of up to 8 cycles.
    localparam int n_slots = 5 + 10 + 2 * n_scalar + 4 + 4 * n_vector + 8 + 17 + 3 + 6 * 8;
    localparam longint watchdog_ns = (n_slots + 20) * 100 * 2;

    typedef struct packed {
        logic [4:0]    addr;
        logic [vw-1:0] data;
        logic [31:0]   cycle; // edge count at which we should be seen high.
    } exp_t;

    logic          clk;
    logic          rst_n;
    logic          inst_valid;
    logic [31:0]   inst;
    logic          s_wb_we;
    logic [4:0]    s_wb_addr;
    logic [xw-1:0] s_wb_data;
    logic          v_wb_we;
    logic [4:0]    v_wb_addr;
    logic [vw-1:0] v_wb_data;
    logic          zero;
    logic          sign;
    logic          err;

    logic [xw-1:0] s_model [`VPROC_NREGS];
    logic [vw-1:0] v_model [`VPROC_NREGS];
    exp_t          s_q [$];
    exp_t          v_q [$];
    logic [31:0]   err_q [$];
    exp_t          s_e;
    exp_t          v_e;
    logic [31:0]   cycle = 0;
    int            seed = 32'h56c0051f;
    int unsigned   mismatches = 0;
    int unsigned   other_fails = 0;
    string         test_name = "reset";

    vproc_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .s_wb_we    (s_wb_we),
        .s_wb_addr  (s_wb_addr),
        .s_wb_data  (s_wb_data),
        .v_wb_we    (v_wb_we),
        .v_wb_addr  (v_wb_addr),
        .v_wb_data  (v_wb_data),
        .zero       (zero),
        .sign       (sign),
        .err        (err)
    );

    bind vproc_top vproc_assertions u_assertions (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_wb_we   (s_wb_we),
        .s_wb_addr (s_wb_addr),
        .v_wb_we   (v_wb_we),
        .zero      (zero),
        .sign      (sign),
        .err       (err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] enc_r(logic [5:0] op, logic [4:0] rd, logic [4:0] rs1,
                                          logic [4:0] rs2);
        return {op, rd, rs1, rs2, 11'd0};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rd, logic [4:0] rs1,
                                          logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic logic [4:0] pick_reg(int n);
        return 5'($unsigned($random(seed)) % n);
    endfunction

    // 0 scalar, 1 vector, 2 illegal.
    function automatic int op_class(logic [5:0] op);
        case (op)
            vproc_isa_pkg::op_sadd, vproc_isa_pkg::op_ssub,
            vproc_isa_pkg::op_saddi, vproc_isa_pkg::op_sand: return 0;
            vproc_isa_pkg::op_vadd, vproc_isa_pkg::op_vmul,
            vproc_isa_pkg::op_vsplat: return 1;
            default: return 2;
        endcase
    endfunction

    function automatic logic [vw-1:0] expected_result(logic [31:0] w);
        logic [xw-1:0] a;
        logic [xw-1:0] b;
        logic [xw-1:0] imm;
        logic [vw-1:0] va;
        logic [vw-1:0] vb;
        logic [vw-1:0] r;
        a   = s_model[w[20:16]];
        b   = s_model[w[15:11]];
        va  = v_model[w[20:16]];
        vb  = v_model[w[15:11]];
        imm = {{(xw-16){w[15]}}, w[15:0]};
        r   = '0;
        case (w[31:26])
            vproc_isa_pkg::op_sadd:   r[xw-1:0] = a + b;
            vproc_isa_pkg::op_ssub:   r[xw-1:0] = a - b;
            vproc_isa_pkg::op_saddi:  r[xw-1:0] = a + imm;
            vproc_isa_pkg::op_sand:   r[xw-1:0] = a & b;
            vproc_isa_pkg::op_vsplat: r = {`VPROC_LANES{a}};
            vproc_isa_pkg::op_vadd, vproc_isa_pkg::op_vmul: begin
                for (int i = 0; i < `VPROC_LANES; i++) begin
                    if (w[31:26] == vproc_isa_pkg::op_vadd) begin
                        r[i*xw +: xw] = va[i*xw +: xw] + vb[i*xw +: xw];
                    end else begin
                        r[i*xw +: xw] = va[i*xw +: xw] * vb[i*xw +: xw];
                    end
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic check(input string what, input logic [vw-1:0] expected,
                         input logic [vw-1:0] actual);
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // called 10 ns after an edge; the instruction is sampled at the next edge.
    task automatic issue(input logic [31:0] w);
        exp_t e;
        int   kind;
        kind       = op_class(w[31:26]);
        e.addr     = w[25:21];
        e.data     = expected_result(w);
        inst_valid = 1'b1;
        inst       = w;
        if (kind == 2) begin
            err_q.push_back(cycle + 1);
        end else if (e.addr != '0) begin
            if (kind == 1) begin
                e.cycle = cycle + 4;
                v_q.push_back(e);
                v_model[e.addr] = e.data;
            end else begin
                e.cycle = cycle + 2;
                s_q.push_back(e);
                s_model[e.addr] = e.data[xw-1:0];
            end
        end
        @(posedge clk);
        #10 inst_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic drain();
        for (int i = 0; i < 8 && (s_q.size() + v_q.size() + err_q.size()) != 0; i++) begin
            @(posedge clk);
            #10;
        end
    endtask

    // outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (rst_n) begin
            if (s_wb_we) begin
                if (s_q.size() == 0) begin
                    other_fails++;
                    $display("%s: scalar writeback to r%0d with no result expected",
                             test_name, s_wb_addr);
                end else begin
                    s_e = s_q.pop_front();
                    check("scalar addr", s_e.addr, s_wb_addr);
                    check("scalar data", s_e.data, s_wb_data);
                    check("scalar latency", s_e.cycle, cycle);
                    check("zero flag", s_e.data[xw-1:0] == '0, zero);
                    check("sign flag", s_e.data[xw-1], sign);
                end
            end
            if (v_wb_we) begin
                if (v_q.size() == 0) begin
                    other_fails++;
                    $display("%s: vector writeback to v%0d with no result expected",
                             test_name, v_wb_addr);
                end else begin
                    v_e = v_q.pop_front();
                    check("vector addr", v_e.addr, v_wb_addr);
                    check("vector data", v_e.data, v_wb_data);
                    check("vector latency", v_e.cycle, cycle);
                end
            end
            if (err) begin
                if (err_q.size() != 0 && err_q[0] == cycle) begin
                    void'(err_q.pop_front());
                end else begin
                    other_fails++;
                    $display("%s: err pulsed at cycle %0d without an illegal instruction",
                             test_name, cycle);
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run still going after %0d ns", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < `VPROC_NREGS; i++) begin
            s_model[i] = '0;
            v_model[i] = '0;
        end
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;

        test_name = "scalar arithmetic";
        for (int i = 1; i <= 8; i++) begin
            issue(enc_i(vproc_isa_pkg::op_saddi, 5'(i), 5'd0, 16'($random(seed))));
        end
        issue(enc_r(vproc_isa_pkg::op_ssub, 5'd9, 5'd1, 5'd1)); // zero result.
        idle(1);
        for (int n = 0; n < n_scalar; n++) begin
            case ($unsigned($random(seed)) % 4)
                0: issue(enc_r(vproc_isa_pkg::op_sadd, pick_reg(10), pick_reg(10), pick_reg(10)));
                1: issue(enc_r(vproc_isa_pkg::op_ssub, pick_reg(10), pick_reg(10), pick_reg(10)));
                2: issue(enc_r(vproc_isa_pkg::op_sand, pick_reg(10), pick_reg(10), pick_reg(10)));
                default: issue(enc_i(vproc_isa_pkg::op_saddi, pick_reg(10), pick_reg(10),
                                     16'($random(seed))));
            endcase
            idle(1);
        end
        drain();

        test_name = "vector operations";
        for (int i = 1; i <= 4; i++) begin
            issue(enc_r(vproc_isa_pkg::op_vsplat, 5'(i), 5'(i), 5'd0));
        end
        drain();
        for (int n = 0; n < n_vector; n++) begin
            if ($random(seed) & 1) begin
                issue(enc_r(vproc_isa_pkg::op_vadd, pick_reg(5), pick_reg(5), pick_reg(5)));
            end else begin
                issue(enc_r(vproc_isa_pkg::op_vmul, pick_reg(5), pick_reg(5), pick_reg(5)));
            end
            idle(3);
        end
        drain();

        test_name = "back-to-back issue";
        for (int i = 0; i < 4; i++) begin
            issue(enc_i(vproc_isa_pkg::op_saddi, 5'(9 + i), 5'(1 + i), 16'($random(seed))));
            issue(enc_r(vproc_isa_pkg::op_vadd, 5'(5 + i), 5'(1 + i), 5'(4 - i)));
        end
        drain();

        test_name = "dependent spacing";
        issue(enc_i(vproc_isa_pkg::op_saddi, 5'd13, 5'd0, 16'($random(seed))));
        idle(1);
        issue(enc_r(vproc_isa_pkg::op_sadd, 5'd14, 5'd13, 5'd13));
        idle(1);
        issue(enc_r(vproc_isa_pkg::op_vsplat, 5'd9, 5'd14, 5'd0));
        idle(3);
        issue(enc_r(vproc_isa_pkg::op_vadd, 5'd10, 5'd9, 5'd9));
        issue(enc_i(vproc_isa_pkg::op_saddi, 5'd0, 5'd0, 16'd123)); // r0 keeps reading zero.
        idle(1);
        issue(enc_r(vproc_isa_pkg::op_sadd, 5'd15, 5'd0, 5'd1));
        issue(enc_r(vproc_isa_pkg::op_vsplat, 5'd0, 5'd1, 5'd0));
        idle(3);
        issue(enc_r(vproc_isa_pkg::op_vadd, 5'd11, 5'd0, 5'd2));
        drain();

        test_name = "illegal opcode";
        issue({6'h3f, 5'd5, 5'd1, 16'd0});
        idle(1);
        issue({6'h00, 5'd6, 5'd2, 16'd0});
        drain();

        if ((s_q.size() + v_q.size() + err_q.size()) != 0) begin
            other_fails++;
            $display("%0d expected results never retired",
                     s_q.size() + v_q.size() + err_q.size());
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, other_fails, dut.u_assertions.fails);
        if ((mismatches + other_fails + dut.u_assertions.fails) == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vproc_top.f */
+incdir+.
vproc_isa_pkg.sv
vproc_ctrl_pkg.sv
wb_if.sv
control_pipeline.sv
decode_regfile.sv
scalar_alu.sv
vector_lanes.sv
vproc_top.sv
vproc_assertions.sv
tb_vproc.sv

/* Bender.yml */
package:
  name: vproc

sources:
  - include_dirs:
      - .
    files:
      - vproc_isa_pkg.sv
      - vproc_ctrl_pkg.sv
      - wb_if.sv
      - control_pipeline.sv
      - decode_regfile.sv
      - scalar_alu.sv
      - vector_lanes.sv
      - vproc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - vproc_assertions.sv
      - tb_vproc.sv
